// File: source/muldiv_params.svh
// Build-time sizes of the multiply/divide pipe. RV32 only.
// XLEN must be a multiple of UNROLL and QDEPTH a power of two.

`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// ------------------------------------------------------------
// Datapath
// ------------------------------------------------------------
`define MULDIV_XLEN 32
`define MULDIV_UNROLL 8                                       // Multiplier bits per stage
`define MULDIV_MUL_STAGES (`MULDIV_XLEN / `MULDIV_UNROLL)

// ------------------------------------------------------------
// Queue and divider
// ------------------------------------------------------------
`define MULDIV_QDEPTH 4                                       // Also the initial credit count
`define MULDIV_DIV_STEPS `MULDIV_XLEN                         // One quotient bit per step

`endif

// File: source/muldiv_data_pkg.sv
// Operand and product widths of the multiply/divide pipe.

`default_nettype none

`include "muldiv_params.svh"

package muldiv_data_pkg;

  // Register operand or result
  typedef logic [`MULDIV_XLEN-1:0] xlen_t;

  // Full product, high word at the top
  typedef logic [2*`MULDIV_XLEN-1:0] dxlen_t;

  // Operand with sign or zero extension bit
  typedef logic [`MULDIV_XLEN:0] opnd_ext_t;

endpackage

`default_nettype wire

// File: source/muldiv_ctrl_pkg.sv
// Operation encoding follows the RV32M funct3 field.
// The tag is opaque here and only travels with the operation.

`default_nettype none

package muldiv_ctrl_pkg;

  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_t;

  typedef logic [3:0] tag_t;

  typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

  function automatic logic is_div_op(muldiv_op_t op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  function automatic logic op_signed_a(muldiv_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
  endfunction

  function automatic logic op_signed_b(muldiv_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};
  endfunction

endpackage

`default_nettype wire

// File: source/muldiv_op_if.sv
// One dispatched operation, queue to unit. Transfers whenever valid is high;
// the unit side has no ready and must be able to take it.

`timescale 1ns/10ps
`default_nettype none

interface muldiv_op_if;
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  logic       valid;
  muldiv_op_t op;
  tag_t       tag;
  xlen_t      rs1;
  xlen_t      rs2;

  modport src (
    output valid, op, tag, rs1, rs2
  );

  modport dst (
    input valid, op, tag, rs1, rs2
  );

endinterface

`default_nettype wire

// File: source/muldiv_issue_queue.sv
// In-order issue FIFO, no overflow check: the issuer's credits keep it from filling.
// An issue presented in the flush cycle is dropped along with the queue contents.

`timescale 1ns/10ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_issue_queue (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset_n,
  input  wire logic                     i_flush,
  input  wire logic                     i_valid,
  input  muldiv_ctrl_pkg::muldiv_op_t   i_op,
  input  muldiv_ctrl_pkg::tag_t         i_tag,
  input  muldiv_data_pkg::xlen_t        i_rs1,
  input  muldiv_data_pkg::xlen_t        i_rs2,
  input  wire logic                     i_div_idle,
  output logic                          o_credit_return,
  muldiv_op_if.src                      mul_op,
  muldiv_op_if.src                      div_op
);
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  localparam int DEPTH = `MULDIV_QDEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  muldiv_op_t       r_op  [DEPTH];
  tag_t             r_tag [DEPTH];
  xlen_t            r_rs1 [DEPTH];
  xlen_t            r_rs2 [DEPTH];
  logic [PTR_W-1:0] r_wptr;
  logic [PTR_W-1:0] r_rptr;
  logic [PTR_W:0]   r_count;

  logic w_push;
  logic w_head_div;
  logic w_dispatch;

  assign w_push     = i_valid & ~i_flush;
  assign w_head_div = is_div_op(r_op[r_rptr]);
  // Divide at the head stalls everything behind it until the divider frees up
  assign w_dispatch = (r_count != '0) & ~i_flush & (~w_head_div | i_div_idle);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else if (i_flush) begin
      r_wptr  <= '0;
      r_rptr  <= '0;
      r_count <= '0;
    end else begin
      if (w_push) r_wptr <= r_wptr + PTR_W'(1);
      if (w_dispatch) r_rptr <= r_rptr + PTR_W'(1);
      r_count <= r_count + (PTR_W+1)'(w_push) - (PTR_W+1)'(w_dispatch);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_op[r_wptr]  <= i_op;
      r_tag[r_wptr] <= i_tag;
      r_rs1[r_wptr] <= i_rs1;
      r_rs2[r_wptr] <= i_rs2;
    end
  end

  // ------------------------------------------------------------
  // Dispatch
  // ------------------------------------------------------------
  assign o_credit_return = w_dispatch;

  assign mul_op.valid = w_dispatch & ~w_head_div;
  assign mul_op.op    = r_op[r_rptr];
  assign mul_op.tag   = r_tag[r_rptr];
  assign mul_op.rs1   = r_rs1[r_rptr];
  assign mul_op.rs2   = r_rs2[r_rptr];

  assign div_op.valid = w_dispatch & w_head_div;
  assign div_op.op    = r_op[r_rptr];
  assign div_op.tag   = r_tag[r_rptr];
  assign div_op.rs1   = r_rs1[r_rptr];
  assign div_op.rs2   = r_rs2[r_rptr];

endmodule

`default_nettype wire

// File: source/muldiv_mul_pipe.sv
// Multiplier, one operation per cycle, result MULDIV_MUL_STAGES cycles after dispatch.
// Sums are kept modulo 2^64, which gives exact low and high words for every sign mode.

`timescale 1ns/10ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_mul_pipe (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire logic                i_flush,
  muldiv_op_if.dst                 mul_op,
  output logic                     o_valid,
  output muldiv_ctrl_pkg::tag_t    o_tag,
  output muldiv_data_pkg::xlen_t   o_res
);
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  localparam int XLEN   = `MULDIV_XLEN;
  localparam int UNROLL = `MULDIV_UNROLL;
  localparam int STAGES = `MULDIV_MUL_STAGES;
  localparam int PP_W   = XLEN + UNROLL + 2;     // 33-bit by 9-bit signed product

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    logic                   w_vld;
    muldiv_op_t             w_op;
    tag_t                   w_tag;
    opnd_ext_t              w_a;
    xlen_t                  w_b;
    dxlen_t                 w_acc_in;
    logic [UNROLL-1:0]      w_slice;
    logic                   w_slice_sign;
    logic signed [PP_W-1:0] w_pp;
    dxlen_t                 w_acc_out;

    logic       r_valid;
    muldiv_op_t r_op;
    tag_t       r_tag;
    dxlen_t     r_acc;

    if (s == 0) begin : g_load
      assign w_vld    = mul_op.valid;
      assign w_op     = mul_op.op;
      assign w_tag    = mul_op.tag;
      assign w_a      = {op_signed_a(mul_op.op) & mul_op.rs1[XLEN-1], mul_op.rs1};
      assign w_b      = mul_op.rs2;
      assign w_acc_in = '0;
    end else begin : g_chain
      assign w_vld    = g_stage[s-1].r_valid;
      assign w_op     = g_stage[s-1].r_op;
      assign w_tag    = g_stage[s-1].r_tag;
      assign w_a      = g_stage[s-1].g_fwd.r_a;
      assign w_b      = g_stage[s-1].g_fwd.r_b;
      assign w_acc_in = g_stage[s-1].r_acc;
    end

    // Top slice carries the sign of a signed operand B
    assign w_slice      = w_b[UNROLL*s +: UNROLL];
    assign w_slice_sign = (s == STAGES-1) && op_signed_b(w_op) && w_slice[UNROLL-1];

    assign w_pp = $signed({{(UNROLL+1){w_a[XLEN]}}, w_a}) *
                  $signed({{(PP_W-UNROLL){w_slice_sign}}, w_slice});
    assign w_acc_out = w_acc_in + ({{(2*XLEN-PP_W){w_pp[PP_W-1]}}, w_pp} << (UNROLL*s));

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid <= 1'b0;
      end else begin
        r_valid <= w_vld & ~i_flush;
      end
    end

    always_ff @(posedge i_clk) begin
      r_op  <= w_op;
      r_tag <= w_tag;
      r_acc <= w_acc_out;
    end

    // Operands only travel as far as a later stage needs them
    if (s < STAGES-1) begin : g_fwd
      opnd_ext_t r_a;
      xlen_t     r_b;

      always_ff @(posedge i_clk) begin
        r_a <= w_a;
        r_b <= w_b;
      end
    end
  end

  // ------------------------------------------------------------
  // Result word select
  // ------------------------------------------------------------
  assign o_valid = g_stage[STAGES-1].r_valid;
  assign o_tag   = g_stage[STAGES-1].r_tag;
  assign o_res   = (g_stage[STAGES-1].r_op == OP_MUL) ? g_stage[STAGES-1].r_acc[XLEN-1:0]
                                                      : g_stage[STAGES-1].r_acc[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: source/muldiv_div_unit.sv
// Restoring divider, one operation at a time, done 33 cycles after acceptance.
// The caller must only present an operation while o_idle is high.

`timescale 1ns/10ps
`default_nettype none

`include "muldiv_params.svh"

module muldiv_div_unit (
  input  wire logic                i_clk,
  input  wire logic                i_reset_n,
  input  wire logic                i_flush,
  muldiv_op_if.dst                 div_op,
  output logic                     o_idle,
  output logic                     o_done,
  output muldiv_ctrl_pkg::tag_t    o_tag,
  output muldiv_data_pkg::xlen_t   o_res,
  input  wire logic                i_taken
);
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  localparam int XLEN  = `MULDIV_XLEN;
  localparam int STEPS = `MULDIV_DIV_STEPS;
  localparam int CNT_W = $clog2(STEPS + 1);

  div_state_t       r_state;
  logic [CNT_W-1:0] r_cnt;
  xlen_t            r_rem;
  xlen_t            r_quo;
  xlen_t            r_dvsr;
  xlen_t            r_dvnd;                      // Original dividend for special cases
  muldiv_op_t       r_op;
  tag_t             r_tag;
  logic             r_neg_q;
  logic             r_neg_r;
  logic             r_zero;
  logic             r_ovf;
  xlen_t            r_res;

  logic      w_accept;
  logic      w_last;
  logic      w_a_neg;
  logic      w_b_neg;
  opnd_ext_t w_shift;
  opnd_ext_t w_diff;
  logic      w_is_rem;
  xlen_t     w_quo_fix;
  xlen_t     w_rem_fix;
  xlen_t     w_res;

  assign w_accept = (r_state == IDLE) & div_op.valid;
  assign w_last   = (r_cnt == CNT_W'(STEPS));
  assign w_a_neg  = op_signed_a(div_op.op) & div_op.rs1[XLEN-1];
  assign w_b_neg  = op_signed_b(div_op.op) & div_op.rs2[XLEN-1];

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
      r_cnt   <= '0;
    end else if (i_flush) begin
      r_state <= IDLE;
    end else begin
      case (r_state)
        IDLE: begin
          if (div_op.valid) begin
            r_state <= RUN;
            r_cnt   <= '0;
          end
        end
        RUN: begin
          if (w_last) r_state <= DONE;              // Sign fix-up cycle
          else r_cnt <= r_cnt + CNT_W'(1);
        end
        DONE: begin
          if (i_taken) r_state <= IDLE;
        end
        default: r_state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  assign w_shift = {r_rem, r_quo[XLEN-1]};
  assign w_diff  = w_shift - {1'b0, r_dvsr};

  assign w_is_rem  = (r_op == OP_REM) | (r_op == OP_REMU);
  assign w_quo_fix = r_neg_q ? -r_quo : r_quo;
  assign w_rem_fix = r_neg_r ? -r_rem : r_rem;
  assign w_res     = r_zero ? (w_is_rem ? r_dvnd : '1) :
                     r_ovf  ? (w_is_rem ? '0 : r_dvnd) :
                     (w_is_rem ? w_rem_fix : w_quo_fix);

  always_ff @(posedge i_clk) begin
    if (w_accept) begin
      r_rem   <= '0;
      r_quo   <= w_a_neg ? -div_op.rs1 : div_op.rs1;
      r_dvsr  <= w_b_neg ? -div_op.rs2 : div_op.rs2;
      r_dvnd  <= div_op.rs1;
      r_op    <= div_op.op;
      r_tag   <= div_op.tag;
      r_neg_q <= w_a_neg ^ w_b_neg;
      r_neg_r <= w_a_neg;
      r_zero  <= (div_op.rs2 == '0);
      r_ovf   <= op_signed_a(div_op.op) & (div_op.rs1 == {1'b1, {(XLEN-1){1'b0}}}) &
                 (&div_op.rs2);
    end else if (r_state == RUN) begin
      if (w_last) begin
        r_res <= w_res;
      end else if (!w_diff[XLEN]) begin
        r_rem <= w_diff[XLEN-1:0];
        r_quo <= {r_quo[XLEN-2:0], 1'b1};
      end else begin
        r_rem <= w_shift[XLEN-1:0];              // Restore
        r_quo <= {r_quo[XLEN-2:0], 1'b0};
      end
    end
  end

  assign o_idle = (r_state == IDLE);
  assign o_done = (r_state == DONE);
  assign o_tag  = r_tag;
  assign o_res  = r_res;

endmodule

`default_nettype wire

// File: source/muldiv_wb_merge.sv
// Single write-back port, multiplier first. The port never stalls,
// so a multiplier result always goes out in its own cycle.

`timescale 1ns/10ps
`default_nettype none

module muldiv_wb_merge (
  input  wire logic                i_mul_valid,
  input  muldiv_ctrl_pkg::tag_t    i_mul_tag,
  input  muldiv_data_pkg::xlen_t   i_mul_res,
  input  wire logic                i_div_done,
  input  muldiv_ctrl_pkg::tag_t    i_div_tag,
  input  muldiv_data_pkg::xlen_t   i_div_res,
  output logic                     o_div_taken,
  output logic                     o_valid,
  output muldiv_ctrl_pkg::tag_t    o_tag,
  output muldiv_data_pkg::xlen_t   o_res
);

  assign o_div_taken = i_div_done & ~i_mul_valid;   // Divide waits out multiplier traffic
  assign o_valid     = i_mul_valid | i_div_done;
  assign o_tag       = i_mul_valid ? i_mul_tag : i_div_tag;
  assign o_res       = i_mul_valid ? i_mul_res : i_div_res;

endmodule

`default_nettype wire

// File: source/muldiv_pipe.sv
// Multiply/divide execution pipe. Issue is credit based, QDEPTH credits at reset
// and after i_flush. The result port has no back-pressure.

`timescale 1ns/10ps
`default_nettype none

module muldiv_pipe (
  input  wire logic                     i_clk,
  input  wire logic                     i_reset_n,
  input  wire logic                     i_flush,
  input  wire logic                     i_valid,
  input  muldiv_ctrl_pkg::muldiv_op_t   i_op,
  input  muldiv_ctrl_pkg::tag_t         i_tag,
  input  muldiv_data_pkg::xlen_t        i_rs1,
  input  muldiv_data_pkg::xlen_t        i_rs2,
  output logic                          o_credit_return,
  output logic                          o_valid,
  output muldiv_ctrl_pkg::tag_t         o_tag,
  output muldiv_data_pkg::xlen_t        o_res
);
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  muldiv_op_if mul_op ();
  muldiv_op_if div_op ();

  logic  w_div_idle;
  logic  w_mul_valid;
  tag_t  w_mul_tag;
  xlen_t w_mul_res;
  logic  w_div_done;
  tag_t  w_div_tag;
  xlen_t w_div_res;
  logic  w_div_taken;

  muldiv_issue_queue u_queue (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush         (i_flush),
    .i_valid         (i_valid),
    .i_op            (i_op),
    .i_tag           (i_tag),
    .i_rs1           (i_rs1),
    .i_rs2           (i_rs2),
    .i_div_idle      (w_div_idle),
    .o_credit_return (o_credit_return),
    .mul_op          (mul_op.src),
    .div_op          (div_op.src)
  );

  muldiv_mul_pipe u_mul (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .mul_op    (mul_op.dst),
    .o_valid   (w_mul_valid),
    .o_tag     (w_mul_tag),
    .o_res     (w_mul_res)
  );

  muldiv_div_unit u_div (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .div_op    (div_op.dst),
    .o_idle    (w_div_idle),
    .o_done    (w_div_done),
    .o_tag     (w_div_tag),
    .o_res     (w_div_res),
    .i_taken   (w_div_taken)
  );

  muldiv_wb_merge u_merge (
    .i_mul_valid (w_mul_valid),
    .i_mul_tag   (w_mul_tag),
    .i_mul_res   (w_mul_res),
    .i_div_done  (w_div_done),
    .i_div_tag   (w_div_tag),
    .i_div_res   (w_div_res),
    .o_div_taken (w_div_taken),
    .o_valid     (o_valid),
    .o_tag       (o_tag),
    .o_res       (o_res)
  );

endmodule

`default_nettype wire

// File: bench/muldiv_chk.sv
// Reference model and assertions for muldiv_pipe, attached by bind.
// Assumes the issuer never reuses a tag that is still in flight.

`timescale 1ns/10ps
`default_nettype none

module muldiv_chk (
  input wire logic                    i_clk,
  input wire logic                    i_reset_n,
  input wire logic                    i_flush,
  input wire logic                    i_valid,
  input muldiv_ctrl_pkg::muldiv_op_t  i_op,
  input muldiv_ctrl_pkg::tag_t        i_tag,
  input muldiv_data_pkg::xlen_t       i_rs1,
  input muldiv_data_pkg::xlen_t       i_rs2,
  input wire logic                    o_credit_return,
  input wire logic                    o_valid,
  input muldiv_ctrl_pkg::tag_t        o_tag,
  input muldiv_data_pkg::xlen_t       o_res
);
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  logic       r_out [16];                        // Tag has a result pending
  xlen_t      r_exp [16];
  int         r_pending;
  int         r_queued;
  int         r_cyc;
  logic [4:0] r_lat_vld;
  tag_t       r_lat_tag [5];

  // Failure record, read by the testbench
  logic  r_fail = 1'b0;
  logic  r_is_value = 1'b0;
  string r_what = "";
  string r_sig = "";
  xlen_t r_err_exp = '0;
  xlen_t r_err_got = '0;

  logic w_issue;
  logic w_lat_start;

  function automatic xlen_t ref_result(muldiv_op_t op, xlen_t a, xlen_t b);
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] prod;
    int          sa;
    int          sb;
    sa = a;
    sb = b;
    a64 = (op == OP_MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
    b64 = (op == OP_MUL || op == OP_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = a64 * b64;
    case (op)
      OP_MUL:   return prod[31:0];
      OP_MULH, OP_MULHSU, OP_MULHU: return prod[63:32];
      OP_DIV:   return (b == '0) ? '1 : (a == 32'h8000_0000 && b == '1) ? a : xlen_t'(sa / sb);
      OP_REM:   return (b == '0) ? a : (a == 32'h8000_0000 && b == '1) ? '0 : xlen_t'(sa % sb);
      OP_DIVU:  return (b == '0) ? '1 : a / b;
      default:  return (b == '0) ? a : a % b;
    endcase
  endfunction

  assign w_issue     = i_valid & ~i_flush;
  // Multiply into an empty pipe, latency is fixed
  assign w_lat_start = w_issue & ~i_op[2] & (r_pending == 0);

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int k = 0; k < 16; k++) r_out[k] <= 1'b0;
      r_pending <= 0;
      r_queued  <= 0;
      r_cyc     <= 0;
      r_lat_vld <= '0;
    end else if (i_flush) begin
      for (int k = 0; k < 16; k++) r_out[k] <= 1'b0;
      r_pending <= 0;
      r_queued  <= 0;
      r_lat_vld <= '0;
    end else begin
      if (r_cyc < 2) r_cyc <= r_cyc + 1;
      if (o_valid) r_out[o_tag] <= 1'b0;
      if (w_issue) begin
        r_out[i_tag] <= 1'b1;
        r_exp[i_tag] <= ref_result(i_op, i_rs1, i_rs2);
      end
      r_pending <= r_pending + (w_issue ? 1 : 0) - (o_valid ? 1 : 0);
      r_queued  <= r_queued + (w_issue ? 1 : 0) - (o_credit_return ? 1 : 0);
      r_lat_vld <= {r_lat_vld[3:0], w_lat_start};
      r_lat_tag[0] <= i_tag;
      for (int k = 1; k < 5; k++) r_lat_tag[k] <= r_lat_tag[k-1];
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  a_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_valid |-> r_out[o_tag])
    else begin
      r_fail = 1'b1;
      r_what = "result with a tag that has no operation outstanding";
      $error("unexpected result tag %0d", o_tag);
    end

  a_value: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_valid && r_out[o_tag]) |-> (o_res == r_exp[o_tag]))
    else begin
      r_fail = 1'b1;
      r_is_value = 1'b1;
      r_sig = "o_res";
      r_err_exp = r_exp[o_tag];
      r_err_got = o_res;
      $error("wrong result for tag %0d", o_tag);
    end

  a_credit: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_credit_return |-> (r_queued > 0))
    else begin
      r_fail = 1'b1;
      r_what = "credit returned with no operation in the queue";
      $error("spurious credit return");
    end

  a_lat_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_lat_vld[4] |-> o_valid)
    else begin
      r_fail = 1'b1;
      r_what = "multiply into an idle pipe did not finish after 5 cycles";
      $error("multiply latency");
    end

  a_lat_tag: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_lat_vld[4] && o_valid) |-> (o_tag == r_lat_tag[4]))
    else begin
      r_fail = 1'b1;
      r_is_value = 1'b1;
      r_sig = "o_tag";
      r_err_exp = xlen_t'(r_lat_tag[4]);
      r_err_got = xlen_t'(o_tag);
      $error("multiply latency tag");
    end

  a_reset: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (r_cyc < 2) |-> (!o_valid && !o_credit_return))
    else begin
      r_fail = 1'b1;
      r_what = "output activity right after reset";
      $error("outputs not quiet after reset");
    end

endmodule

bind muldiv_pipe muldiv_chk u_chk (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_flush         (i_flush),
  .i_valid         (i_valid),
  .i_op            (i_op),
  .i_tag           (i_tag),
  .i_rs1           (i_rs1),
  .i_rs2           (i_rs2),
  .o_credit_return (o_credit_return),
  .o_valid         (o_valid),
  .o_tag           (o_tag),
  .o_res           (o_res)
);

`default_nettype wire

// File: bench/muldiv_tb.sv
// Testbench for muldiv_pipe. Checking lives in the bound muldiv_chk;
// tags are never reused while in flight and credits are never overspent.

`timescale 1ns/10ps
`default_nettype none

module muldiv_tb;
  import muldiv_ctrl_pkg::*;
  import muldiv_data_pkg::*;

  localparam int LIMIT = 300 * 40 + 2000;        // Cycles

  logic       i_clk;
  logic       i_reset_n;
  logic       i_flush;
  logic       i_valid;
  muldiv_op_t i_op;
  tag_t       i_tag;
  xlen_t      i_rs1;
  xlen_t      i_rs2;
  logic       o_credit_return;
  logic       o_valid;
  tag_t       o_tag;
  xlen_t      o_res;

  integer seed = 58380;
  int     credits = 4;
  int     busy_count = 0;
  int     cycles = 0;
  logic   tag_busy [16];
  tag_t   next_tag = '0;

  muldiv_pipe dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, operations still outstanding", LIMIT);
      $display("Test failed");
      $fatal(1);
    end
  end

  // Report the first checker failure
  always @(negedge i_clk) begin
    if (dut0.u_chk.r_fail) begin
      if (dut0.u_chk.r_is_value)
        $display("ERR time=%0t signal=%s expected=%h got=%h", $time, dut0.u_chk.r_sig,
                 dut0.u_chk.r_err_exp, dut0.u_chk.r_err_got);
      else
        $display("%s at time %0t", dut0.u_chk.r_what, $time);
      $display("Test failed");
      $fatal(1);
    end
  end

  // Advance one edge and account for returned credits and results
  task automatic tick();
    @(posedge i_clk);
    if (o_credit_return) credits++;
    if (o_valid && tag_busy[o_tag]) begin
      tag_busy[o_tag] = 1'b0;
      busy_count--;
    end
    i_valid <= 1'b0;
    i_flush <= 1'b0;
  endtask

  task automatic issue_op(input muldiv_op_t op, input xlen_t a, input xlen_t b);
    bit sent;
    sent = 1'b0;
    while (!sent) begin
      tick();
      if (credits > 0 && !tag_busy[next_tag]) begin
        i_valid <= 1'b1;
        i_op    <= op;
        i_tag   <= next_tag;
        i_rs1   <= a;
        i_rs2   <= b;
        tag_busy[next_tag] = 1'b1;
        busy_count++;
        credits--;
        next_tag = next_tag + 4'd1;
        sent = 1'b1;
      end
    end
  endtask

  task automatic drain();
    while (busy_count != 0) tick();
    repeat (2) tick();
  endtask

  task automatic flush_now();
    tick();
    i_flush <= 1'b1;
    tick();
    credits = 4;
    busy_count = 0;
    for (int k = 0; k < 16; k++) tag_busy[k] = 1'b0;
  endtask

  function automatic xlen_t pick_operand();
    logic [2:0] sel;
    sel = 3'($random(seed));
    case (sel)
      3'd0:    return 32'h8000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return (($random(seed) & 1) != 0) ? 32'h0 : 32'h7fff_ffff;
      default: return $random(seed);
    endcase
  endfunction

  task automatic random_op();
    logic [1:0] kind;
    kind = 2'($random(seed));
    if (($random(seed) & 7) == 0)
      issue_op(muldiv_op_t'({1'b1, kind}), pick_operand(), pick_operand());
    else
      issue_op(muldiv_op_t'({1'b0, kind}), pick_operand(), pick_operand());
    if (($random(seed) & 15) == 0) tick();
  endtask

  initial begin
    for (int k = 0; k < 16; k++) tag_busy[k] = 1'b0;
    i_reset_n = 1'b0;
    i_flush   = 1'b0;
    i_valid   = 1'b0;
    i_op      = OP_MUL;
    i_tag     = '0;
    i_rs1     = '0;
    i_rs2     = '0;
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;
    repeat (3) tick();

    // ------------------------------------------------------------
    // Directed cases, each into an idle pipe
    // ------------------------------------------------------------
    issue_op(OP_MUL, 32'd1234, 32'd5678);
    drain();
    issue_op(OP_MULH, 32'hffff_fff0, 32'h8000_0000);
    drain();
    issue_op(OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
    drain();
    issue_op(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    drain();
    issue_op(OP_DIV, 32'd77, 32'd0);                 // Divide by zero
    issue_op(OP_REMU, 32'd77, 32'd0);
    drain();
    issue_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff);  // Signed overflow
    issue_op(OP_REM, 32'h8000_0000, 32'hffff_ffff);
    drain();

    // ------------------------------------------------------------
    // Random traffic, then a flush with work in flight
    // ------------------------------------------------------------
    repeat (300) random_op();
    drain();
    issue_op(OP_DIVU, 32'd1000, 32'd7);
    repeat (5) issue_op(OP_MULHU, pick_operand(), pick_operand());
    flush_now();
    repeat (8) random_op();
    drain();

    if (dut0.u_chk.r_fail || dut0.u_chk.r_pending != 0) begin
      $display("Results missing or checker error at end of run");
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: muldiv.f
+incdir+source
source/muldiv_data_pkg.sv
source/muldiv_ctrl_pkg.sv
source/muldiv_op_if.sv
source/muldiv_issue_queue.sv
source/muldiv_mul_pipe.sv
source/muldiv_div_unit.sv
source/muldiv_wb_merge.sv
source/muldiv_pipe.sv
bench/muldiv_chk.sv
bench/muldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the multiply/divide pipe testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module muldiv_tb -f muldiv.f -o muldiv_sim

out=$(./obj_dir/muldiv_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test passed"; then
  exit 0
else
  exit 1
fi
